/* all.f */
hdl/jacobi_pkg.sv
hdl/cordic_pkg.sv
hdl/matrix_ram.sv
hdl/pair_scheduler.sv
hdl/pair_fetch.sv
hdl/cordic_stage.sv
hdl/angle_collector.sv
hdl/jacobi_angle_top.sv
sim/tb_jacobi_angle.sv

/* run.sh */
#!/bin/sh
# Build and run the Jacobi angle testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_jacobi_angle -Mdir obj_dir -o sim_tb; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/sim_tb > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "ALL TESTS PASSED" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* sim/tb_jacobi_angle.sv */
module tb_jacobi_angle;
  timeunit 1ns;
  timeprecision 100ps;

  import jacobi_pkg::*;
  import cordic_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int N_MATRICES   = 2;
  localparam int TOTAL_WORDS  = N_MATRICES * JACOBI_N_WORDS;
  localparam int TOTAL_ANGLES = N_MATRICES * JACOBI_N_ANGLES;
  localparam int ANGLE_TOL    = 8;
  // Two matrices of about 400 cycles each at half rate on both ports plus wide margin
  localparam int TIMEOUT_CYCLES = 3000;
  localparam real PI = 3.14159265358979323846;

  logic   clk;
  logic   rst;
  word_t  in_dat_i;
  logic   in_vld_i;
  logic   in_rdy_o;
  angle_t out_dat_o;
  logic   out_vld_o;
  logic   out_last_o;
  logic   out_rdy_i;

  word_t  words [TOTAL_WORDS];
  int     sched_lo [JACOBI_N_ANGLES];
  int     sched_hi [JACOBI_N_ANGLES];
  int     exp_angle [TOTAL_ANGLES];
  int     exp_now;
  int     acc_cnt;
  int     out_cnt;
  int     cycle_cnt;
  int     rdy_wait_q;
  logic   rst_q;
  logic   busy_q;
  logic   hold_q;
  angle_t prev_dat_q;
  logic   prev_last_q;

  jacobi_angle_top u_dut (
    .clk        (clk),
    .rst        (rst),
    .in_dat_i   (in_dat_i),
    .in_vld_i   (in_vld_i),
    .in_rdy_o   (in_rdy_o),
    .out_dat_o  (out_dat_o),
    .out_vld_o  (out_vld_o),
    .out_last_o (out_last_o),
    .out_rdy_i  (out_rdy_i)
  );

  always #2 clk = ~clk;

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  // atan2(2*Wij, Wjj - Wii) as a binary angle wrapped to 16 bits
  function automatic int expected_angle(input word_t wii, input word_t wjj, input word_t wij);
    real x;
    real y;
    real s;
    int  e;
    x = real'(wjj) - real'(wii);
    y = 2.0 * real'(wij);
    s = $atan2(y, x) * 32768.0 / PI;
    e = (s >= 0.0) ? $rtoi(s + 0.5) : $rtoi(s - 0.5);
    if (e >= 32768) begin
      e = e - 65536;
    end
    return e;
  endfunction

  function automatic logic angle_close(input angle_t got, input int expv);
    angle_t d;
    d = got - angle_t'(expv);
    return (d <= ANGLE_TOL) && (d >= -ANGLE_TOL);
  endfunction

  function automatic int quadrant_offdiag(input int i, input int j);
    int mag;
    if (i == 0 && j == 1) return 3000;
    if (i == 2 && j == 3) return 500;
    if (i == 4 && j == 5) return -500;
    if (i == 6 && j == 7) return 0;
    mag = ((i * 7 + j * 13) % 9 + 3) * 700;
    return ((i + j) % 2 == 1) ? -mag : mag;
  endfunction

  task automatic build_matrices();
    int diag [JACOBI_N];
    int v;
    // Second matrix diagonal picked for the quadrant cases
    diag = '{4000, 4000, 12000, -12000, 12000, -12000, 3000, 7000};
    for (int i = 0; i < JACOBI_N; i++) begin
      for (int j = i; j < JACOBI_N; j++) begin
        if (i == j) begin
          v = int'($urandom_range(32000)) - 16000;
        end else begin
          // Keep vectors long so CORDIC truncation stays small
          v = 2048 + int'($urandom_range(13999));
          if ($urandom % 2 == 1) begin
            v = -v;
          end
        end
        words[i * JACOBI_N + j] = word_t'(v);
        words[j * JACOBI_N + i] = word_t'(v);
        v = (i == j) ? diag[i] : quadrant_offdiag(i, j);
        words[JACOBI_N_WORDS + i * JACOBI_N + j] = word_t'(v);
        words[JACOBI_N_WORDS + j * JACOBI_N + i] = word_t'(v);
      end
    end
  endtask

  task automatic build_schedule();
    int first [JACOBI_N_PAIRS];
    int second [JACOBI_N_PAIRS];
    int ring [JACOBI_N - 1];
    bit seen [JACOBI_N][JACOBI_N];
    int n;
    int lo;
    int hi;
    for (int k = 0; k < JACOBI_N_PAIRS; k++) begin
      first[k]  = k;
      second[k] = JACOBI_N - 1 - k;
    end
    n = 0;
    for (int r = 0; r < JACOBI_N_ROUNDS; r++) begin
      for (int k = 0; k < JACOBI_N_PAIRS; k++) begin
        lo = (first[k] < second[k]) ? first[k] : second[k];
        hi = (first[k] < second[k]) ? second[k] : first[k];
        sched_lo[n] = lo;
        sched_hi[n] = hi;
        assert (!seen[lo][hi]) else stop_with_error("reference schedule repeats a pair");
        seen[lo][hi] = 1'b1;
        n++;
      end
      // Ring positions in walking order around the fixed index 0
      ring = '{second[0], second[1], second[2], second[3], first[3], first[2], first[1]};
      second[0] = ring[6];
      second[1] = ring[0];
      second[2] = ring[1];
      second[3] = ring[2];
      first[3]  = ring[3];
      first[2]  = ring[4];
      first[1]  = ring[5];
    end
    for (int i = 0; i < JACOBI_N; i++) begin
      for (int j = i + 1; j < JACOBI_N; j++) begin
        assert (seen[i][j]) else stop_with_error("reference schedule misses a pair");
      end
    end
  endtask

  task automatic build_expected();
    int base;
    int lo;
    int hi;
    for (int m = 0; m < N_MATRICES; m++) begin
      base = m * JACOBI_N_WORDS;
      for (int n = 0; n < JACOBI_N_ANGLES; n++) begin
        lo = sched_lo[n];
        hi = sched_hi[n];
        exp_angle[m * JACOBI_N_ANGLES + n] = expected_angle(words[base + lo * JACOBI_N + lo],
                                                            words[base + hi * JACOBI_N + hi],
                                                            words[base + lo * JACOBI_N + hi]);
      end
    end
  endtask

  assign exp_now = (out_cnt < TOTAL_ANGLES) ? exp_angle[out_cnt] : 0;

  // Handshake bookkeeping over both matrices sent back to back
  always @(posedge clk) begin
    rst_q <= rst;
    if (rst) begin
      acc_cnt    <= 0;
      out_cnt    <= 0;
      busy_q     <= 1'b0;
      hold_q     <= 1'b0;
      rdy_wait_q <= 0;
    end else begin
      if (rdy_wait_q != 0) begin
        rdy_wait_q <= (rdy_wait_q == 3) ? 0 : rdy_wait_q + 1;
      end
      if (in_vld_i && in_rdy_o) begin
        acc_cnt <= acc_cnt + 1;
        if (acc_cnt % JACOBI_N_WORDS == JACOBI_N_WORDS - 1) begin
          busy_q <= 1'b1;
        end
      end
      if (out_vld_o && out_rdy_i) begin
        out_cnt <= out_cnt + 1;
        if (out_last_o) begin
          busy_q     <= 1'b0;
          rdy_wait_q <= 1;
        end
      end
      hold_q      <= out_vld_o && !out_rdy_i;
      prev_dat_q  <= out_dat_o;
      prev_last_q <= out_last_o;
    end
  end

  always @(negedge clk) begin
    if (!rst_q) begin
      if (acc_cnt < TOTAL_WORDS) begin
        in_dat_i = words[acc_cnt];
        in_vld_i = ($urandom % 2) == 1;
      end else begin
        in_vld_i = 1'b0;
      end
      out_rdy_i = ($urandom % 2) == 1;
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      stop_with_error("timeout, the DUT did not deliver all angles in time");
    end
  end

  a_reset_state: assert property (@(posedge clk)
    (rst_q && !rst) |-> (in_rdy_o && !out_vld_o && !out_last_o))
    else stop_with_error($sformatf(
      "mismatch at %0t: in_rdy_o/out_vld_o/out_last_o got %b%b%b expected 100", $time,
      $sampled(in_rdy_o), $sampled(out_vld_o), $sampled(out_last_o)));

  a_no_early_out: assert property (@(posedge clk) disable iff (rst) out_vld_o |-> busy_q)
    else stop_with_error($sformatf("mismatch at %0t: out_vld_o got 1 expected 0", $time));

  a_rdy_low: assert property (@(posedge clk) disable iff (rst) busy_q |-> !in_rdy_o)
    else stop_with_error($sformatf("mismatch at %0t: in_rdy_o got 1 expected 0", $time));

  a_rdy_back: assert property (@(posedge clk) disable iff (rst) (rdy_wait_q == 3) |-> in_rdy_o)
    else stop_with_error($sformatf("mismatch at %0t: in_rdy_o got 0 expected 1", $time));

  a_angle: assert property (@(posedge clk) disable iff (rst)
    (out_vld_o && out_rdy_i) |-> angle_close(out_dat_o, exp_now))
    else stop_with_error($sformatf("mismatch at %0t: out_dat_o got %0d expected %0d", $time,
      $sampled(out_dat_o), $sampled(exp_now)));

  a_last: assert property (@(posedge clk) disable iff (rst)
    out_vld_o |-> (out_last_o == (out_cnt % JACOBI_N_ANGLES == JACOBI_N_ANGLES - 1)))
    else stop_with_error($sformatf("mismatch at %0t: out_last_o got %b expected %b", $time,
      $sampled(out_last_o),
      ($sampled(out_cnt) % JACOBI_N_ANGLES == JACOBI_N_ANGLES - 1)));

  // Held output under back-pressure
  a_hold_dat: assert property (@(posedge clk) disable iff (rst) hold_q |-> out_dat_o == prev_dat_q)
    else stop_with_error($sformatf("mismatch at %0t: out_dat_o got %0d expected %0d", $time,
      $sampled(out_dat_o), $sampled(prev_dat_q)));

  a_hold_vld: assert property (@(posedge clk) disable iff (rst) hold_q |-> out_vld_o)
    else stop_with_error($sformatf("mismatch at %0t: out_vld_o got 0 expected 1", $time));

  a_hold_last: assert property (@(posedge clk) disable iff (rst)
    hold_q |-> out_last_o == prev_last_q)
    else stop_with_error($sformatf("mismatch at %0t: out_last_o got %b expected %b", $time,
      $sampled(out_last_o), $sampled(prev_last_q)));

  initial begin
    void'($urandom(32'h4448_e441));
    clk       = 1'b0;
    rst       = 1'b1;
    in_dat_i  = '0;
    in_vld_i  = 1'b0;
    out_rdy_i = 1'b0;
    cycle_cnt = 0;
    build_matrices();
    build_schedule();
    build_expected();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    wait (out_cnt == TOTAL_ANGLES);
    repeat (4) @(negedge clk);
    if (acc_cnt == TOTAL_WORDS && !busy_q && in_rdy_o) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      stop_with_error("run ended with the DUT still busy or words not accepted");
    end
  end

endmodule

/* hdl/jacobi_angle_top.sv */
module jacobi_angle_top (
  input  logic               clk,
  input  logic               rst,
  input  jacobi_pkg::word_t  in_dat_i,
  input  logic               in_vld_i,
  output logic               in_rdy_o,
  output cordic_pkg::angle_t out_dat_o,
  output logic               out_vld_o,
  output logic               out_last_o,
  input  logic               out_rdy_i
);
  import jacobi_pkg::*;
  import cordic_pkg::*;

  logic       a_en;
  logic       a_we;
  addr_t      a_addr;
  word_t      a_din;
  word_t      a_dout;
  logic       b_en;
  addr_t      b_addr;
  word_t      b_dout;
  index_t     pair_lo;
  index_t     pair_hi;
  logic       next_pair;
  logic       next_round;
  logic       round_sent;

  // Entry 0 comes from pair_fetch, entry k+1 from stage k
  cordic_xy_t cx [CORDIC_ITER+1];
  cordic_xy_t cy [CORDIC_ITER+1];
  angle_t     cz [CORDIC_ITER+1];
  logic       cv [CORDIC_ITER+1];

  matrix_ram u_ram (
    .clk      (clk),
    .a_en_i   (a_en),
    .a_we_i   (a_we),
    .a_addr_i (a_addr),
    .a_din_i  (a_din),
    .a_dout_o (a_dout),
    .b_en_i   (b_en),
    .b_addr_i (b_addr),
    .b_dout_o (b_dout)
  );

  pair_scheduler u_sched (
    .clk          (clk),
    .rst          (rst),
    .next_pair_i  (next_pair),
    .next_round_i (next_round),
    .lo_o         (pair_lo),
    .hi_o         (pair_hi)
  );

  pair_fetch u_fetch (
    .clk          (clk),
    .rst          (rst),
    .in_dat_i     (in_dat_i),
    .in_vld_i     (in_vld_i),
    .in_rdy_o     (in_rdy_o),
    .a_en_o       (a_en),
    .a_we_o       (a_we),
    .a_addr_o     (a_addr),
    .a_din_o      (a_din),
    .b_en_o       (b_en),
    .b_addr_o     (b_addr),
    .rd_a_i       (a_dout),
    .rd_b_i       (b_dout),
    .lo_i         (pair_lo),
    .hi_i         (pair_hi),
    .next_pair_o  (next_pair),
    .next_round_o (next_round),
    .x_o          (cx[0]),
    .y_o          (cy[0]),
    .z_o          (cz[0]),
    .vld_o        (cv[0]),
    .round_sent_i (round_sent)
  );

  for (genvar k = 0; k < CORDIC_ITER; k++) begin : g_stage
    cordic_stage #(
      .STAGE (k)
    ) u_stage (
      .clk   (clk),
      .rst   (rst),
      .x_i   (cx[k]),
      .y_i   (cy[k]),
      .z_i   (cz[k]),
      .vld_i (cv[k]),
      .x_o   (cx[k+1]),
      .y_o   (cy[k+1]),
      .z_o   (cz[k+1]),
      .vld_o (cv[k+1])
    );
  end

  angle_collector u_collect (
    .clk          (clk),
    .rst          (rst),
    .z_i          (cz[CORDIC_ITER]),
    .vld_i        (cv[CORDIC_ITER]),
    .out_dat_o    (out_dat_o),
    .out_vld_o    (out_vld_o),
    .out_last_o   (out_last_o),
    .out_rdy_i    (out_rdy_i),
    .round_sent_o (round_sent)
  );

endmodule

/* hdl/angle_collector.sv */
module angle_collector (
  input  logic               clk,
  input  logic               rst,
  input  cordic_pkg::angle_t z_i,
  input  logic               vld_i,
  output cordic_pkg::angle_t out_dat_o,
  output logic               out_vld_o,
  output logic               out_last_o,
  input  logic               out_rdy_i,
  output logic               round_sent_o
);
  import jacobi_pkg::*;
  import cordic_pkg::*;

  angle_t     buf_q [JACOBI_N_PAIRS];
  pair_cnt_t  cap_cnt_q;
  pair_cnt_t  snd_cnt_q;
  round_cnt_t round_cnt_q;
  logic       xfer;
  logic [$bits(round_cnt_t)+$bits(pair_cnt_t)-1:0] angle_idx;

  assign xfer      = out_vld_o && out_rdy_i;
  assign out_dat_o = buf_q[0];

  // Angle number within the matrix, round*4 + slot
  assign angle_idx  = {round_cnt_q, snd_cnt_q};
  assign out_last_o = out_vld_o && (angle_idx == JACOBI_N_ANGLES - 1);

  // Captures enter at the top, transfers pop from the bottom.
  // Both never overlap since the next round waits for round_sent
  always_ff @(posedge clk) begin
    if (vld_i || xfer) begin
      buf_q[JACOBI_N_PAIRS-1] <= z_i;
      for (int k = 0; k < JACOBI_N_PAIRS - 1; k++) begin
        buf_q[k] <= buf_q[k+1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cap_cnt_q    <= '0;
      snd_cnt_q    <= '0;
      round_cnt_q  <= '0;
      out_vld_o    <= 1'b0;
      round_sent_o <= 1'b0;
    end else begin
      round_sent_o <= 1'b0;
      if (vld_i) begin
        cap_cnt_q <= cap_cnt_q + 1'b1;
        if (cap_cnt_q == pair_cnt_t'(JACOBI_N_PAIRS - 1)) begin
          out_vld_o <= 1'b1;
        end
      end
      if (xfer) begin
        snd_cnt_q <= snd_cnt_q + 1'b1;
        if (snd_cnt_q == pair_cnt_t'(JACOBI_N_PAIRS - 1)) begin
          out_vld_o    <= 1'b0;
          round_sent_o <= 1'b1;
          if (round_cnt_q == round_cnt_t'(JACOBI_N_ROUNDS - 1)) begin
            round_cnt_q <= '0;
          end else begin
            round_cnt_q <= round_cnt_q + 1'b1;
          end
        end
      end
    end
  end

endmodule

/* hdl/cordic_stage.sv */
module cordic_stage #(
  parameter int STAGE = 0
) (
  input  logic                   clk,
  input  logic                   rst,
  input  cordic_pkg::cordic_xy_t x_i,
  input  cordic_pkg::cordic_xy_t y_i,
  input  cordic_pkg::angle_t     z_i,
  input  logic                   vld_i,
  output cordic_pkg::cordic_xy_t x_o,
  output cordic_pkg::cordic_xy_t y_o,
  output cordic_pkg::angle_t     z_o,
  output logic                   vld_o
);
  import cordic_pkg::*;

  cordic_xy_t x_sh;
  cordic_xy_t y_sh;

  assign x_sh = x_i >>> STAGE;
  assign y_sh = y_i >>> STAGE;

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_o <= 1'b0;
    end else begin
      vld_o <= vld_i;
    end
  end

  // Drive y towards zero, z collects the rotated angle
  always_ff @(posedge clk) begin
    if (vld_i) begin
      if (y_i[CORDIC_W-1]) begin
        x_o <= x_i - y_sh;
        y_o <= y_i + x_sh;
        z_o <= z_i - CORDIC_ATAN[STAGE];
      end else begin
        x_o <= x_i + y_sh;
        y_o <= y_i - x_sh;
        z_o <= z_i + CORDIC_ATAN[STAGE];
      end
    end
  end

endmodule

/* hdl/pair_fetch.sv */
module pair_fetch (
  input  logic                   clk,
  input  logic                   rst,
  input  jacobi_pkg::word_t      in_dat_i,
  input  logic                   in_vld_i,
  output logic                   in_rdy_o,
  output logic                   a_en_o,
  output logic                   a_we_o,
  output jacobi_pkg::addr_t      a_addr_o,
  output jacobi_pkg::word_t      a_din_o,
  output logic                   b_en_o,
  output jacobi_pkg::addr_t      b_addr_o,
  input  jacobi_pkg::word_t      rd_a_i,
  input  jacobi_pkg::word_t      rd_b_i,
  input  jacobi_pkg::index_t     lo_i,
  input  jacobi_pkg::index_t     hi_i,
  output logic                   next_pair_o,
  output logic                   next_round_o,
  output cordic_pkg::cordic_xy_t x_o,
  output cordic_pkg::cordic_xy_t y_o,
  output cordic_pkg::angle_t     z_o,
  output logic                   vld_o,
  input  logic                   round_sent_i
);
  import jacobi_pkg::*;
  import cordic_pkg::*;

  typedef enum logic [2:0] {IDLE, RECEIVE, PUSH, WAIT_ROUND, SEND} state_t;

  state_t     state_q;
  addr_t      wr_cnt_q;
  logic       wr_q;
  addr_t      wr_addr_q;
  word_t      wr_dat_q;
  logic       phase_q;
  pair_cnt_t  pair_cnt_q;
  round_cnt_t round_cnt_q;
  logic       rd_ph0_q;
  logic       rd_ph1_q;
  word_t      wjj_q;
  word_t      wij_q;
  logic       accept;
  logic       rd_en;
  cordic_xy_t dx;
  cordic_xy_t dy;

  assign in_rdy_o = (state_q == IDLE) || (state_q == RECEIVE);
  assign accept   = in_vld_i && in_rdy_o;

  // The last load write still owns port A in the first PUSH cycle
  assign rd_en = (state_q == PUSH) && !wr_q;

  assign a_en_o  = wr_q || rd_en;
  assign a_we_o  = wr_q;
  assign a_din_o = wr_dat_q;

  // Phase 0 reads Wjj and Wij, phase 1 reads Wii
  always_comb begin
    if (wr_q) begin
      a_addr_o = wr_addr_q;
    end else if (phase_q) begin
      a_addr_o = {lo_i, lo_i};
    end else begin
      a_addr_o = {hi_i, hi_i};
    end
  end

  assign b_en_o   = rd_en && !phase_q;
  assign b_addr_o = {lo_i, hi_i};

  assign next_pair_o  = rd_en && phase_q;
  assign next_round_o = (state_q == SEND) && round_sent_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_q     <= 1'b0;
      wr_cnt_q <= '0;
    end else begin
      wr_q <= accept;
      if (accept) begin
        wr_cnt_q <= wr_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wr_addr_q <= wr_cnt_q;
      wr_dat_q  <= in_dat_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= IDLE;
      phase_q     <= 1'b0;
      pair_cnt_q  <= '0;
      round_cnt_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= RECEIVE;
          end
        end
        RECEIVE: begin
          if (accept && wr_cnt_q == addr_t'(JACOBI_N_WORDS - 1)) begin
            state_q <= PUSH;
          end
        end
        PUSH: begin
          if (rd_en) begin
            phase_q <= !phase_q;
            if (phase_q) begin
              pair_cnt_q <= pair_cnt_q + 1'b1;
              if (pair_cnt_q == pair_cnt_t'(JACOBI_N_PAIRS - 1)) begin
                state_q <= WAIT_ROUND;
              end
            end
          end
        end
        WAIT_ROUND: begin
          // Let the RAM read pipe drain
          if (!rd_ph0_q && !rd_ph1_q) begin
            state_q <= SEND;
          end
        end
        SEND: begin
          if (round_sent_i) begin
            if (round_cnt_q == round_cnt_t'(JACOBI_N_ROUNDS - 1)) begin
              round_cnt_q <= '0;
              state_q     <= IDLE;
            end else begin
              round_cnt_q <= round_cnt_q + 1'b1;
              state_q     <= PUSH;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ph0_q <= 1'b0;
      rd_ph1_q <= 1'b0;
      vld_o    <= 1'b0;
    end else begin
      rd_ph0_q <= rd_en && !phase_q;
      rd_ph1_q <= rd_en && phase_q;
      vld_o    <= rd_ph1_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_ph0_q) begin
      wjj_q <= rd_a_i;
      wij_q <= rd_b_i;
    end
  end

  // Wii is on port A while rd_ph1_q is high
  always_comb begin
    dx = wjj_q - rd_a_i;
    dy = wij_q + wij_q;
  end

  always_ff @(posedge clk) begin
    if (rd_ph1_q) begin
      if (dx[CORDIC_W-1]) begin
        // Left half plane, fold by pi. +pi and -pi share one code
        x_o <= -dx;
        y_o <= -dy;
        z_o <= {1'b1, {(ANGLE_W - 1){1'b0}}};
      end else begin
        x_o <= dx;
        y_o <= dy;
        z_o <= '0;
      end
    end
  end

endmodule

/* hdl/pair_scheduler.sv */
module pair_scheduler (
  input  logic               clk,
  input  logic               rst,
  input  logic               next_pair_i,
  input  logic               next_round_i,
  output jacobi_pkg::index_t lo_o,
  output jacobi_pkg::index_t hi_o
);
  import jacobi_pkg::*;

  index_t first_q  [JACOBI_N_PAIRS];
  index_t second_q [JACOBI_N_PAIRS];

  always_ff @(posedge clk) begin
    if (rst) begin
      // (0,7) (1,6) (2,5) (3,4)
      for (int k = 0; k < JACOBI_N_PAIRS; k++) begin
        first_q[k]  <= index_t'(k);
        second_q[k] <= index_t'(JACOBI_N - 1 - k);
      end
    end else if (next_pair_i) begin
      // Slot 1 moves to the front, four steps restore the order
      for (int k = 0; k < JACOBI_N_PAIRS; k++) begin
        first_q[k]  <= first_q[(k + 1) % JACOBI_N_PAIRS];
        second_q[k] <= second_q[(k + 1) % JACOBI_N_PAIRS];
      end
    end else if (next_round_i) begin
      // Index 0 stays in first_q[0], the other seven walk the ring
      second_q[1] <= second_q[0];
      second_q[2] <= second_q[1];
      second_q[3] <= second_q[2];
      first_q[3]  <= second_q[3];
      first_q[2]  <= first_q[3];
      first_q[1]  <= first_q[2];
      second_q[0] <= first_q[1];
    end
  end

  always_comb begin
    if (first_q[0] < second_q[0]) begin
      lo_o = first_q[0];
      hi_o = second_q[0];
    end else begin
      lo_o = second_q[0];
      hi_o = first_q[0];
    end
  end

endmodule

/* hdl/matrix_ram.sv */
module matrix_ram (
  input  logic              clk,
  input  logic              a_en_i,
  input  logic              a_we_i,
  input  jacobi_pkg::addr_t a_addr_i,
  input  jacobi_pkg::word_t a_din_i,
  output jacobi_pkg::word_t a_dout_o,
  input  logic              b_en_i,
  input  jacobi_pkg::addr_t b_addr_i,
  output jacobi_pkg::word_t b_dout_o
);
  import jacobi_pkg::*;

  word_t mem [JACOBI_N_WORDS];

  // Port A writes during load and reads during the angle pass
  always_ff @(posedge clk) begin
    if (a_en_i) begin
      if (a_we_i) begin
        mem[a_addr_i] <= a_din_i;
      end
      a_dout_o <= mem[a_addr_i];
    end
  end

  always_ff @(posedge clk) begin
    if (b_en_i) begin
      b_dout_o <= mem[b_addr_i];
    end
  end

endmodule

/* hdl/cordic_pkg.sv */
package cordic_pkg;

  // Headroom for a 17-bit difference times the CORDIC gain of about 1.647
  localparam int CORDIC_W    = 20;
  localparam int CORDIC_ITER = 14;
  localparam int ANGLE_W     = 16;

  typedef logic signed [CORDIC_W-1:0] cordic_xy_t;

  // Binary angle, -32768 is -pi and one LSB is pi/32768
  typedef logic signed [ANGLE_W-1:0] angle_t;

  // atan(2^-k) scaled by 32768/pi
  localparam angle_t CORDIC_ATAN [CORDIC_ITER] = '{
    16'sd8192,
    16'sd4836,
    16'sd2555,
    16'sd1297,
    16'sd651,
    16'sd326,
    16'sd163,
    16'sd81,
    16'sd41,
    16'sd20,
    16'sd10,
    16'sd5,
    16'sd3,
    16'sd1
  };

endpackage

/* hdl/jacobi_pkg.sv */
package jacobi_pkg;

  // Matrix geometry
  localparam int JACOBI_N        = 8;
  localparam int JACOBI_LOG2_N   = 3;
  localparam int JACOBI_N_WORDS  = JACOBI_N * JACOBI_N;
  localparam int JACOBI_ADDR_W   = 2 * JACOBI_LOG2_N;
  localparam int JACOBI_WORD_W   = 16;

  // Round-robin schedule, every unordered pair once per matrix
  localparam int JACOBI_N_PAIRS  = JACOBI_N / 2;
  localparam int JACOBI_N_ROUNDS = JACOBI_N - 1;
  localparam int JACOBI_N_ANGLES = JACOBI_N_PAIRS * JACOBI_N_ROUNDS;

  typedef logic [JACOBI_LOG2_N-1:0] index_t;

  // Address is 8*row + column, so {row, col} concatenated
  typedef logic [JACOBI_ADDR_W-1:0] addr_t;

  typedef logic signed [JACOBI_WORD_W-1:0] word_t;

  typedef logic [$clog2(JACOBI_N_PAIRS)-1:0] pair_cnt_t;
  typedef logic [$clog2(JACOBI_N_ROUNDS)-1:0] round_cnt_t;

endpackage
